// ==== hdl/iq_cfg_pkg.sv ====
// Queue sizes; PTR_W must equal log2(QUEUE_DEPTH) and QUEUE_DEPTH a power of two so pointers wrap.
package iq_cfg_pkg;

  // queue geometry
  localparam int QUEUE_DEPTH = 16; // entries in the circular buffer.
  localparam int WRITE_LANES = 4;  // instructions per fetch group.
  localparam int READ_LANES  = 2;  // entries offered to decode per cycle.

  // payload widths
  localparam int INSTR_W = 80; // instruction bits.
  localparam int OTHER_W = 16; // side-band bits such as predicted target and flags.

  // index and count widths
  localparam int PTR_W   = 4; // slot index, wraps at QUEUE_DEPTH.
  localparam int COUNT_W = 5; // occupancy must also hold QUEUE_DEPTH itself.

endpackage

// ==== hdl/iq_types_pkg.sv ====
// Entry and group types; lane 0 of a group is the lowest element and the oldest instruction.
package iq_types_pkg;
  import iq_cfg_pkg::*;

  // one stored instruction with its side-band bits
  typedef struct packed {
    logic [INSTR_W-1:0] instr;
    logic [OTHER_W-1:0] other;
  } iq_entry_t;

  // slot index into the ring.
  typedef logic [PTR_W-1:0] iq_ptr_t;

  // occupancy, 0 up to QUEUE_DEPTH.
  typedef logic [COUNT_W-1:0] iq_count_t;

  // a fetch group as written in one cycle.
  typedef iq_entry_t [WRITE_LANES-1:0] iq_wgroup_t;

  // the oldest entries as seen by decode.
  typedef iq_entry_t [READ_LANES-1:0] iq_rgroup_t;

endpackage

// ==== hdl/iq_write_ctrl.sv ====
// Fetch-side control; lanes after the first clear bit of write_instr_en are dropped, stalled writes are lost.
module iq_write_ctrl (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               except,
  input  logic                               write_wen,
  input  logic [iq_cfg_pkg::WRITE_LANES-1:0] write_instr_en,
  input  logic                               fetch_stall,
  output iq_types_pkg::iq_count_t            push_count,
  output logic [iq_cfg_pkg::WRITE_LANES-1:0] slot_we,
  output iq_types_pkg::iq_ptr_t              slot_addr [iq_cfg_pkg::WRITE_LANES]
);
  import iq_cfg_pkg::*;
  import iq_types_pkg::*;

  iq_ptr_t   wr_ptr;
  iq_count_t lane_count;
  logic      accept;

  assign accept = write_wen & ~fetch_stall; // the fetch side re-presents a stalled group.

  // length of the leading run of set lanes, starting at lane 0
  always_comb begin : count_lanes
    logic run;
    lane_count = '0;
    run = 1'b1;
    for (int i = 0; i < WRITE_LANES; i++) begin
      run = run & write_instr_en[i];
      lane_count = lane_count + iq_count_t'(run);
    end
  end

  assign push_count = accept ? lane_count : '0;

  // lane i lands in the slot i places after the write pointer.
  always_comb begin
    for (int i = 0; i < WRITE_LANES; i++) begin
      slot_we[i]   = accept && (iq_count_t'(i) < lane_count);
      slot_addr[i] = wr_ptr + iq_ptr_t'(i); // wraps at the end of the ring.
    end
  end

  always_ff @(posedge clk) begin
    if (rst || except) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr + iq_ptr_t'(push_count); // push_count never exceeds WRITE_LANES.
    end
  end

endmodule

// ==== hdl/iq_ring.sv ====
// Entry storage; write slots within one cycle must differ, and contents are undefined until written.
module iq_ring (
  input  logic                               clk,
  input  logic [iq_cfg_pkg::WRITE_LANES-1:0] slot_we,
  input  iq_types_pkg::iq_ptr_t              slot_addr [iq_cfg_pkg::WRITE_LANES],
  input  iq_types_pkg::iq_wgroup_t           write_group,
  input  iq_types_pkg::iq_ptr_t              rd_ptr,
  output iq_types_pkg::iq_rgroup_t           head_group
);
  import iq_cfg_pkg::*;
  import iq_types_pkg::*;

  iq_entry_t mem [QUEUE_DEPTH];

  // every enabled lane writes its own slot.
  always_ff @(posedge clk) begin
    for (int i = 0; i < WRITE_LANES; i++) begin
      if (slot_we[i]) begin
        mem[slot_addr[i]] <= write_group[i];
      end
    end
  end

  // read lane i sees the entry i slots past the head.
  always_comb begin
    for (int i = 0; i < READ_LANES; i++) begin
      head_group[i] = mem[rd_ptr + iq_ptr_t'(i)];
    end
  end

endmodule

// ==== hdl/iq_read_ctrl.sv ====
// Decode-side control; consume bits beyond the available entries or after the first clear bit are ignored.
module iq_read_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              except,
  input  iq_types_pkg::iq_count_t           push_count,
  input  logic                              read_clk_en,
  input  logic [iq_cfg_pkg::READ_LANES-1:0] read_instr_en,
  input  iq_types_pkg::iq_rgroup_t          head_group,
  output iq_types_pkg::iq_ptr_t             rd_ptr,
  output logic [iq_cfg_pkg::READ_LANES-1:0] read_avail,
  output iq_types_pkg::iq_rgroup_t          read_group,
  output logic                              fetch_stall
);
  import iq_cfg_pkg::*;
  import iq_types_pkg::*;

  iq_count_t occupancy;
  iq_count_t pop_count;

  // lane i is valid while more than i entries are held.
  always_comb begin
    for (int i = 0; i < READ_LANES; i++) begin
      read_avail[i] = occupancy > iq_count_t'(i);
      read_group[i] = read_avail[i] ? head_group[i] : '0; // empty lanes read as zero.
    end
  end

  // consumed count is the leading run of requested and available lanes
  always_comb begin : count_pops
    logic run;
    pop_count = '0;
    run = read_clk_en;
    for (int i = 0; i < READ_LANES; i++) begin
      run = run & read_instr_en[i] & read_avail[i];
      pop_count = pop_count + iq_count_t'(run);
    end
  end

  // stall while less than one full write group of space is left.
  assign fetch_stall = (iq_count_t'(QUEUE_DEPTH) - occupancy) < iq_count_t'(WRITE_LANES);

  always_ff @(posedge clk) begin
    if (rst || except) begin
      occupancy <= '0;
      rd_ptr    <= '0;
    end else begin
      occupancy <= occupancy + push_count - pop_count; // a push and a pop may share an edge.
      rd_ptr    <= rd_ptr + iq_ptr_t'(pop_count);
    end
  end

endmodule

// ==== hdl/iq_top.sv ====
// Single-thread instruction queue; writes are visible one cycle after their edge, except wins over both sides.
module iq_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               except,
  input  logic                               write_wen,
  input  logic [iq_cfg_pkg::WRITE_LANES-1:0] write_instr_en,
  input  iq_types_pkg::iq_wgroup_t           write_group,
  output logic                               fetch_stall,
  input  logic                               read_clk_en,
  input  logic [iq_cfg_pkg::READ_LANES-1:0]  read_instr_en,
  output logic [iq_cfg_pkg::READ_LANES-1:0]  read_avail,
  output iq_types_pkg::iq_rgroup_t           read_group
);
  import iq_cfg_pkg::*;
  import iq_types_pkg::*;

  iq_count_t              push_count;
  logic [WRITE_LANES-1:0] slot_we;
  iq_ptr_t                slot_addr [WRITE_LANES];
  iq_ptr_t                rd_ptr;
  iq_rgroup_t             head_group;

  iq_write_ctrl u_write_ctrl (
    .clk            (clk),
    .rst            (rst),
    .except         (except),
    .write_wen      (write_wen),
    .write_instr_en (write_instr_en),
    .fetch_stall    (fetch_stall),
    .push_count     (push_count),
    .slot_we        (slot_we),
    .slot_addr      (slot_addr)
  );

  iq_ring u_ring (
    .clk         (clk),
    .slot_we     (slot_we),
    .slot_addr   (slot_addr),
    .write_group (write_group),
    .rd_ptr      (rd_ptr),
    .head_group  (head_group)
  );

  iq_read_ctrl u_read_ctrl (
    .clk           (clk),
    .rst           (rst),
    .except        (except),
    .push_count    (push_count),
    .read_clk_en   (read_clk_en),
    .read_instr_en (read_instr_en),
    .head_group    (head_group),
    .rd_ptr        (rd_ptr),
    .read_avail    (read_avail),
    .read_group    (read_group),
    .fetch_stall   (fetch_stall)
  );

endmodule

// ==== verification/tb_iq_top.sv ====
// Directed tests against a queue model; assumes 4 write lanes, 2 read lanes and 96-bit entries.
module tb_iq_top;
  timeunit 1ns;
  timeprecision 100ps;
  import iq_cfg_pkg::*;
  import iq_types_pkg::*;

  logic                   clk;
  logic                   rst;
  logic                   except;
  logic                   write_wen;
  logic [WRITE_LANES-1:0] write_instr_en;
  iq_wgroup_t             write_group;
  logic                   fetch_stall;
  logic                   read_clk_en;
  logic [READ_LANES-1:0]  read_instr_en;
  logic [READ_LANES-1:0]  read_avail;
  iq_rgroup_t             read_group;

  iq_entry_t model_q [$]; // oldest entry at index 0.
  int        errors;

  iq_top u_iq_top (
    .clk            (clk),
    .rst            (rst),
    .except         (except),
    .write_wen      (write_wen),
    .write_instr_en (write_instr_en),
    .write_group    (write_group),
    .fetch_stall    (fetch_stall),
    .read_clk_en    (read_clk_en),
    .read_instr_en  (read_instr_en),
    .read_avail     (read_avail),
    .read_group     (read_group)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // number of set bits before the first clear one, counted from bit 0.
  function automatic int leading_ones(logic [WRITE_LANES-1:0] mask, int lanes);
    int n;
    n = 0;
    for (int i = 0; i < lanes; i++) begin
      if (!mask[i]) break;
      n++;
    end
    return n;
  endfunction

  function automatic iq_entry_t random_entry();
    return {$urandom(), $urandom(), $urandom()};
  endfunction

  task automatic check_value(string name, logic [95:0] actual, logic [95:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_outputs();
    iq_entry_t exp_lane;
    logic      exp_stall;
    for (int i = 0; i < READ_LANES; i++) begin
      exp_lane = (model_q.size() > i) ? model_q[i] : '0; // empty lanes read as zero.
      check_value($sformatf("read_avail[%0d]", i), 96'(read_avail[i]), 96'(model_q.size() > i));
      check_value($sformatf("read_group[%0d]", i), read_group[i], exp_lane);
    end
    exp_stall = (QUEUE_DEPTH - model_q.size()) < WRITE_LANES;
    check_value("fetch_stall", 96'(fetch_stall), 96'(exp_stall));
  endtask

  // drives one cycle from a falling edge and checks the outputs at the next one.
  task automatic do_cycle(logic wen, logic [WRITE_LANES-1:0] wmask, logic ren,
                          logic [READ_LANES-1:0] rmask, logic exc);
    iq_wgroup_t group;
    int         pops;
    int         pushes;
    for (int i = 0; i < WRITE_LANES; i++) begin
      group[i] = random_entry();
    end
    write_wen      = wen;
    write_instr_en = wmask;
    write_group    = group;
    read_clk_en    = ren;
    read_instr_en  = rmask;
    except         = exc;
    pops = ren ? leading_ones(WRITE_LANES'(rmask), READ_LANES) : 0;
    if (pops > model_q.size()) begin
      pops = model_q.size();
    end
    pushes = 0;
    if (wen && (QUEUE_DEPTH - model_q.size()) >= WRITE_LANES) begin
      pushes = leading_ones(wmask, WRITE_LANES);
    end
    @(posedge clk);
    if (exc) begin
      model_q.delete(); // flush wins over both sides.
    end else begin
      repeat (pops) void'(model_q.pop_front());
      for (int i = 0; i < pushes; i++) begin
        model_q.push_back(group[i]);
      end
    end
    @(negedge clk);
    check_outputs();
  endtask

  task automatic drain_queue();
    int guard;
    guard = 0;
    while (model_q.size() > 0) begin
      if (guard == 40) begin
        errors++;
        $display("timeout: the queue did not drain within 40 cycles");
        break;
      end
      do_cycle(1'b0, '0, 1'b1, 2'b11, 1'b0);
      guard++;
    end
  endtask

  task automatic test_reset();
    check_outputs();
  endtask

  task automatic test_in_order();
    do_cycle(1'b1, 4'b0001, 1'b0, '0, 1'b0);
    do_cycle(1'b1, 4'b0111, 1'b0, '0, 1'b0);
    do_cycle(1'b1, 4'b1111, 1'b0, '0, 1'b0);
    do_cycle(1'b1, 4'b1011, 1'b0, '0, 1'b0); // the gap cuts the group after lane 1.
    do_cycle(1'b0, '0, 1'b1, 2'b01, 1'b0);
    do_cycle(1'b0, '0, 1'b1, 2'b10, 1'b0); // lane 0 clear, so nothing is consumed.
    do_cycle(1'b0, '0, 1'b1, 2'b11, 1'b0);
    drain_queue();
  endtask

  task automatic test_back_pressure();
    int guard;
    guard = 0;
    while (!fetch_stall) begin
      if (guard == 20) begin
        errors++;
        $display("timeout: fetch_stall did not rise within 20 full writes");
        break;
      end
      do_cycle(1'b1, 4'b1111, 1'b0, '0, 1'b0);
      guard++;
    end
    do_cycle(1'b1, 4'b1111, 1'b0, '0, 1'b0); // dropped while stalled.
    do_cycle(1'b0, '0, 1'b1, 2'b11, 1'b0);
    do_cycle(1'b0, '0, 1'b1, 2'b11, 1'b0);
    do_cycle(1'b1, 4'b1111, 1'b0, '0, 1'b0);
    drain_queue();
  endtask

  task automatic test_flush();
    do_cycle(1'b1, 4'b1111, 1'b0, '0, 1'b0);
    do_cycle(1'b1, 4'b0111, 1'b0, '0, 1'b0);
    do_cycle(1'b1, 4'b1111, 1'b1, 2'b11, 1'b1);
    do_cycle(1'b1, 4'b0011, 1'b0, '0, 1'b0);
    do_cycle(1'b0, '0, 1'b1, 2'b01, 1'b0);
    drain_queue();
  endtask

  task automatic test_wrap();
    for (int n = 0; n < 200; n++) begin
      do_cycle(1'($urandom()), 4'($urandom()), 1'($urandom()), 2'($urandom()), 1'b0);
    end
  endtask

  initial begin
    void'($urandom(49696));
    errors         = 0;
    rst            = 1'b1;
    except         = 1'b0;
    write_wen      = 1'b0;
    write_instr_en = '0;
    write_group    = '0;
    read_clk_en    = 1'b0;
    read_instr_en  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_in_order();
    test_back_pressure();
    test_flush();
    test_wrap();
    $display("tests done, errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/iq_cfg_pkg.sv
hdl/iq_types_pkg.sv
hdl/iq_write_ctrl.sv
hdl/iq_ring.sv
hdl/iq_read_ctrl.sv
hdl/iq_top.sv
verification/tb_iq_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the instruction queue testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f vlog.f --top-module tb_iq_top -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtb_iq_top > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log

grep -q "RESULT: FAIL" sim.log \
  && { echo "simulation reported failure"; exit 1; }

grep -q "RESULT: PASS" sim.log \
  || { echo "no pass result found in sim.log"; exit 1; }

echo "simulation passed"
exit 0
